//--- src/core_settings.svh
/*
 * Architectural sizes of the integer core.
 * Included by the package and by any module that needs a raw width.
 */

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

//////////////////////////////
// Data path

// Width of a data word and of every register
`define CORE_WORD_W 32

//////////////////////////////
// Register file

`define CORE_REG_N  32  // Registers, r0 included
`define CORE_REG_AW 5   // Bits in a register number

//////////////////////////////
// Instruction word

// Lowest bit of the 6-bit opcode field
`define CORE_OPC_LSB 10

`endif

//--- src/core_pkg.sv
/*
 * Types shared by the pipeline stages of the integer core.
 * Modules refer to them with core_pkg:: scoped names.
 */

`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_WORD_W-1:0] word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    // Low opcode bits of the register forms map straight onto this
    typedef enum logic [3:0] {
        alu_mov = 4'b0000,
        alu_add = 4'b0001,
        alu_sub = 4'b0010,
        alu_shl = 4'b0100,
        alu_shr = 4'b0101,
        alu_sar = 4'b0111,
        alu_or  = 4'b1100,
        alu_and = 4'b1101,
        alu_xor = 4'b1110,
        alu_not = 4'b1111
    } alu_op_t;

    // Bit order follows the PSW flag nibble
    typedef struct packed {
        logic carry;
        logic over;
        logic sign;
        logic zero;
    } alu_flags_t;

    typedef logic [1:0] src1_sel_t;
    localparam src1_sel_t src1_reg  = 2'd0;
    localparam src1_sel_t src1_imm5 = 2'd1;
    localparam src1_sel_t src1_cond = 2'd2;  // SETF condition result

    typedef logic [1:0] src2_sel_t;
    localparam src2_sel_t src2_reg      = 2'd0;
    localparam src2_sel_t src2_imm16    = 2'd1;
    localparam src2_sel_t src2_imm16_hi = 2'd2;

    //////////////////////////////
    // Stage payloads

    typedef struct packed {
        logic       valid;
        alu_op_t    alu_op;
        src1_sel_t  src1_sel;
        src2_sel_t  src2_sel;
        logic       sign_ext;   // Extend the selected immediate as signed
        logic [3:0] cond;       // SETF condition code
        alu_flags_t flag_mask;
        logic       reg_we;
        reg_addr_t  src1_addr;
        reg_addr_t  src2_addr;
        reg_addr_t  dest;
        word_t      operand1;
        word_t      operand2;
        logic [15:0] imm;       // imm5 sits in the low bits
    } decoded_op_t;

    typedef struct packed {
        logic       valid;
        logic       reg_we;
        reg_addr_t  dest;
        word_t      data;
        alu_flags_t flags;
        alu_flags_t flag_mask;
    } stage_result_t;

    typedef struct packed {
        logic      valid;
        logic      reg_we;
        reg_addr_t dest;
        word_t     data;
    } retire_t;

endpackage

//--- src/reg_file.sv
/*
 * General register file, two read ports and one write port.
 * r0 is hardwired to zero. A write shows up on a read of the same
 * register in the same cycle, so decode never sees a stale value.
 */

`timescale 1ns/1ns

`include "core_settings.svh"

module reg_file (
    input  logic              CLK,
    input  core_pkg::reg_addr_t ra1,
    input  core_pkg::reg_addr_t ra2,
    output core_pkg::word_t   rd1,
    output core_pkg::word_t   rd2,
    input  core_pkg::reg_addr_t wa,
    input  core_pkg::word_t   wd,
    input  logic              we
);

    // No storage behind r0
    core_pkg::word_t regs [1:`CORE_REG_N-1];

    always_ff @(posedge CLK) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    //////////////////////////////
    // Read ports

    always_comb begin
        if (ra1 == '0)
            rd1 = '0;
        else if (we && wa == ra1)
            rd1 = wd;           // Write-through
        else
            rd1 = regs[ra1];
    end

    always_comb begin
        if (ra2 == '0)
            rd2 = '0;
        else if (we && wa == ra2)
            rd2 = wd;           // Write-through
        else
            rd2 = regs[ra2];
    end

endmodule

//--- src/instr_decode.sv
/*
 * Decode stage. Splits the instruction word, reads both operands
 * from the register file and registers the decoded operation for
 * execute. Opcodes outside the kept set raise a one-cycle illegal.
 */

`timescale 1ns/1ns

`include "core_settings.svh"

module instr_decode (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  core_pkg::word_t       instr,
    output core_pkg::reg_addr_t   ra1,
    output core_pkg::reg_addr_t   ra2,
    input  core_pkg::word_t       rd1,
    input  core_pkg::word_t       rd2,
    output core_pkg::decoded_op_t dec_op,
    output logic                  illegal
);

    localparam core_pkg::alu_flags_t mask_all =
        '{carry: 1'b1, over: 1'b1, sign: 1'b1, zero: 1'b1};
    // Logic ops and shifts leave carry alone
    localparam core_pkg::alu_flags_t mask_logic =
        '{carry: 1'b0, over: 1'b1, sign: 1'b1, zero: 1'b1};

    logic [5:0]            opc;
    logic                  known;
    core_pkg::decoded_op_t dec_nxt;

    assign opc = instr[`CORE_OPC_LSB +: 6];
    assign ra1 = instr[4:0];
    assign ra2 = instr[9:5];

    //////////////////////////////
    // Opcode match

    always_comb begin
        dec_nxt = '0;
        known = 1'b1;

        // Defaults cover most register and imm5 forms
        dec_nxt.alu_op = core_pkg::alu_op_t'(opc[3:0]);
        dec_nxt.src1_sel = opc[4] ? core_pkg::src1_imm5 : core_pkg::src1_reg;
        dec_nxt.src2_sel = core_pkg::src2_reg;
        dec_nxt.reg_we = 1'b1;

        casez (opc)
            6'b0?000?: begin                    // MOV, ADD
                dec_nxt.sign_ext = 1'b1;
                if (opc[0])
                    dec_nxt.flag_mask = mask_all;
            end
            6'b000010: begin                    // SUB
                dec_nxt.flag_mask = mask_all;
            end
            6'b0?0011: begin                    // CMP
                dec_nxt.alu_op = core_pkg::alu_sub;
                dec_nxt.sign_ext = 1'b1;
                dec_nxt.flag_mask = mask_all;
                dec_nxt.reg_we = 1'b0;          // Flags only
            end
            6'b0?010?,                          // SHL, SHR
            6'b0?0111: begin                    // SAR
                dec_nxt.flag_mask = mask_logic; // imm5 stays unsigned
            end
            6'b0011??: begin                    // OR, AND, XOR, NOT
                dec_nxt.flag_mask = mask_logic;
            end
            6'b010010: begin                    // SETF
                dec_nxt.alu_op = core_pkg::alu_mov;
                dec_nxt.src1_sel = core_pkg::src1_cond;
            end
            6'b10100?: begin                    // MOVEA, ADDI
                dec_nxt.alu_op = core_pkg::alu_add;
                dec_nxt.src2_sel = core_pkg::src2_imm16;
                dec_nxt.sign_ext = 1'b1;
                if (opc[0])
                    dec_nxt.flag_mask = mask_all;
            end
            6'b10110?,                          // ORI, ANDI
            6'b101110: begin                    // XORI
                dec_nxt.src2_sel = core_pkg::src2_imm16;
                dec_nxt.flag_mask = mask_logic;
            end
            6'b101111: begin                    // MOVHI
                dec_nxt.alu_op = core_pkg::alu_add;
                dec_nxt.src2_sel = core_pkg::src2_imm16_hi;
            end
            default: begin
                known = 1'b0;
            end
        endcase

        dec_nxt.valid = instr_valid & known;
        dec_nxt.cond = instr[3:0];
        dec_nxt.src1_addr = instr[4:0];
        dec_nxt.src2_addr = instr[9:5];
        dec_nxt.dest = instr[9:5];
        dec_nxt.operand1 = rd1;
        dec_nxt.operand2 = rd2;

        // imm5 shares the reg1 field
        if (dec_nxt.src1_sel == core_pkg::src1_imm5)
            dec_nxt.imm = {11'b0, instr[4:0]};
        else
            dec_nxt.imm = instr[31:16];

        if (dec_nxt.dest == '0)
            dec_nxt.reg_we = 1'b0;  // r0 writes are dropped
    end

    //////////////////////////////
    // Decode/execute register

    always_ff @(posedge CLK) begin
        dec_op <= dec_nxt;
        illegal <= instr_valid & ~known;
        if (rst) begin
            dec_op.valid <= 1'b0;
            illegal <= 1'b0;
        end
    end

endmodule

//--- src/alu_execute.sv
/*
 * Execute stage. Bypasses the result stage onto register operands,
 * builds both ALU sources, computes result and flags, evaluates the
 * SETF condition and registers the outcome for writeback.
 */

`timescale 1ns/1ns

`include "core_settings.svh"

module alu_execute (
    input  logic                    CLK,
    input  logic                    rst,
    input  core_pkg::decoded_op_t   dec_op,
    input  core_pkg::stage_result_t res_fwd,
    input  core_pkg::alu_flags_t    flags_fwd,
    output core_pkg::stage_result_t ex_res
);

    localparam int msb = `CORE_WORD_W - 1;

    core_pkg::word_t         opnd1, opnd2;
    core_pkg::word_t         src1, src2;
    core_pkg::word_t         imm5_ext, imm16_ext;
    core_pkg::word_t         result;
    logic [4:0]              shamt;
    logic                    cond_raw, cond_match;
    core_pkg::alu_flags_t    alu_fl;
    core_pkg::stage_result_t ex_nxt;

    // Result stage value wins over the operand read in decode
    function automatic core_pkg::word_t bypass(core_pkg::stage_result_t fwd,
                                               core_pkg::reg_addr_t addr,
                                               core_pkg::word_t rd);
        if (fwd.valid && fwd.reg_we && fwd.dest == addr)
            return fwd.data;
        return rd;
    endfunction

    assign opnd1 = bypass(res_fwd, dec_op.src1_addr, dec_op.operand1);
    assign opnd2 = bypass(res_fwd, dec_op.src2_addr, dec_op.operand2);

    //////////////////////////////
    // Source selection

    assign imm5_ext = dec_op.sign_ext ? {{(`CORE_WORD_W-5){dec_op.imm[4]}}, dec_op.imm[4:0]}
                                      : {{(`CORE_WORD_W-5){1'b0}}, dec_op.imm[4:0]};
    assign imm16_ext = dec_op.sign_ext ? {{(`CORE_WORD_W-16){dec_op.imm[15]}}, dec_op.imm}
                                       : {{(`CORE_WORD_W-16){1'b0}}, dec_op.imm};

    always_comb begin
        case (dec_op.src1_sel)
            core_pkg::src1_imm5: src1 = imm5_ext;
            core_pkg::src1_cond: src1 = {{(`CORE_WORD_W-1){1'b0}}, cond_match};
            default:             src1 = opnd1;
        endcase
        case (dec_op.src2_sel)
            core_pkg::src2_imm16:    src2 = imm16_ext;
            core_pkg::src2_imm16_hi: src2 = {dec_op.imm, 16'b0};
            default:                 src2 = opnd2;
        endcase
    end

    //////////////////////////////
    // SETF condition

    always_comb begin
        case (dec_op.cond[2:0])
            3'd0: cond_raw = flags_fwd.over;
            3'd1: cond_raw = flags_fwd.carry;
            3'd2: cond_raw = flags_fwd.zero;
            3'd3: cond_raw = flags_fwd.carry | flags_fwd.zero;     // Not higher
            3'd4: cond_raw = flags_fwd.sign;
            3'd5: cond_raw = 1'b1;
            3'd6: cond_raw = flags_fwd.sign ^ flags_fwd.over;      // Signed less
            default: cond_raw = (flags_fwd.sign ^ flags_fwd.over) | flags_fwd.zero;
        endcase
        cond_match = cond_raw ^ dec_op.cond[3];  // Bit 3 negates
    end

    //////////////////////////////
    // ALU, result is src2 op src1

    assign shamt = src1[4:0];

    always_comb begin
        alu_fl = '0;
        case (dec_op.alu_op)
            core_pkg::alu_add: begin
                {alu_fl.carry, result} = {1'b0, src2} + {1'b0, src1};
                alu_fl.over = (src1[msb] == src2[msb]) & (src2[msb] != result[msb]);
            end
            core_pkg::alu_sub: begin
                {alu_fl.carry, result} = {1'b0, src2} - {1'b0, src1};  // Borrow
                alu_fl.over = (src1[msb] != src2[msb]) & (src2[msb] != result[msb]);
            end
            core_pkg::alu_shl: result = src2 << shamt;
            core_pkg::alu_shr: result = src2 >> shamt;
            core_pkg::alu_sar: result = $signed(src2) >>> shamt;
            core_pkg::alu_or:  result = src2 | src1;
            core_pkg::alu_and: result = src2 & src1;
            core_pkg::alu_xor: result = src2 ^ src1;
            core_pkg::alu_not: result = ~src1;
            default:           result = src1;        // MOV, SETF
        endcase
        alu_fl.zero = ~|result;
        alu_fl.sign = result[msb];
    end

    always_comb begin
        ex_nxt.valid = dec_op.valid;
        ex_nxt.reg_we = dec_op.reg_we;
        ex_nxt.dest = dec_op.dest;
        ex_nxt.data = result;
        ex_nxt.flags = alu_fl;
        ex_nxt.flag_mask = dec_op.flag_mask;
    end

    always_ff @(posedge CLK) begin
        ex_res <= ex_nxt;
        if (rst)
            ex_res.valid <= 1'b0;
    end

endmodule

//--- src/result_writeback.sv
/*
 * Writeback stage. Retires the execute result, writes the register
 * file and keeps the flag register. The masked flag update is also
 * handed back to execute so a SETF right behind a CMP sees it.
 */

`timescale 1ns/1ns

module result_writeback (
    input  logic                    CLK,
    input  logic                    rst,
    input  core_pkg::stage_result_t ex_res,
    output core_pkg::reg_addr_t     wa,
    output core_pkg::word_t         wd,
    output logic                    we,
    output core_pkg::alu_flags_t    flags_fwd,
    output core_pkg::alu_flags_t    flags,
    output core_pkg::retire_t       retire
);

    core_pkg::alu_flags_t flag_reg;

    // Only the masked bits take the new value
    always_comb begin
        if (ex_res.valid)
            flags_fwd = (flag_reg & ~ex_res.flag_mask) | (ex_res.flags & ex_res.flag_mask);
        else
            flags_fwd = flag_reg;
    end

    always_ff @(posedge CLK) begin
        if (rst)
            flag_reg <= '0;
        else
            flag_reg <= flags_fwd;
    end

    assign flags = flag_reg;

    //////////////////////////////
    // Register write and retire

    assign wa = ex_res.dest;
    assign wd = ex_res.data;
    assign we = ex_res.valid & ex_res.reg_we;

    assign retire.valid = ex_res.valid;
    assign retire.reg_we = ex_res.reg_we;
    assign retire.dest = ex_res.dest;
    assign retire.data = ex_res.data;

endmodule

//--- src/int_core.sv
/*
 * Integer core top level. Three stages, decode, execute and
 * writeback, around the register file. One instruction may enter
 * per cycle and retires two cycles later.
 */

`timescale 1ns/1ns

module int_core (
    input  logic              CLK,
    input  logic              rst,
    input  logic              instr_valid,
    input  core_pkg::word_t   instr,
    output core_pkg::retire_t retire,
    output core_pkg::alu_flags_t flags,
    output logic              illegal
);

    core_pkg::reg_addr_t     ra1, ra2, wa;
    core_pkg::word_t         rd1, rd2, wd;
    logic                    we;
    core_pkg::decoded_op_t   dec_op;
    core_pkg::stage_result_t ex_res;
    core_pkg::alu_flags_t    flags_fwd;

    instr_decode i_decode (
        .CLK         (CLK),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ra1         (ra1),
        .ra2         (ra2),
        .rd1         (rd1),
        .rd2         (rd2),
        .dec_op      (dec_op),
        .illegal     (illegal)
    );

    reg_file i_reg_file (
        .CLK (CLK),
        .ra1 (ra1),
        .ra2 (ra2),
        .rd1 (rd1),
        .rd2 (rd2),
        .wa  (wa),
        .wd  (wd),
        .we  (we)
    );

    // Result stage loops back as the bypass source
    alu_execute i_execute (
        .CLK       (CLK),
        .rst       (rst),
        .dec_op    (dec_op),
        .res_fwd   (ex_res),
        .flags_fwd (flags_fwd),
        .ex_res    (ex_res)
    );

    result_writeback i_writeback (
        .CLK       (CLK),
        .rst       (rst),
        .ex_res    (ex_res),
        .wa        (wa),
        .wd        (wd),
        .we        (we),
        .flags_fwd (flags_fwd),
        .flags     (flags),
        .retire    (retire)
    );

endmodule

//--- testbench/tb_int_core.sv
/*
 * Directed testbench for the integer core. A reference model tracks
 * registers and flags in program order and schedules the expected
 * retire, illegal pulse and flag value per cycle for a checker that
 * samples the DUT on the falling clock edge.
 */

`timescale 1ns/1ns

module tb_int_core;

    localparam int max_cyc = 4000;  // Also the run limit
    localparam logic [10:0][5:0] reg_ops =
        {6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h07, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
    localparam logic [5:0][5:0] imm5_ops = {6'h10, 6'h11, 6'h13, 6'h14, 6'h15, 6'h17};
    localparam logic [5:0][5:0] imm16_ops = {6'h28, 6'h29, 6'h2c, 6'h2d, 6'h2e, 6'h2f};
    localparam logic [4:0][5:0] chain_ops = {6'h01, 6'h02, 6'h0c, 6'h0d, 6'h0e};

    logic                 CLK;
    logic                 rst;
    logic                 instr_valid;
    core_pkg::word_t      instr;
    core_pkg::retire_t    retire;
    core_pkg::alu_flags_t flags;
    logic                 illegal;

    // Reference model state
    core_pkg::word_t      m_reg [32];
    core_pkg::alu_flags_t m_flags;
    logic [31:0]          lcg_state;

    // Per-cycle expectations
    core_pkg::retire_t    exp_ret [max_cyc + 8];
    core_pkg::alu_flags_t flag_upd [max_cyc + 8];
    bit                   ret_due [max_cyc + 8];
    bit                   ill_due [max_cyc + 8];
    bit                   flag_due [max_cyc + 8];
    core_pkg::alu_flags_t exp_flags;
    int                   cyc;
    int                   pending;
    int                   errors;
    bit                   mon_on;

    int_core i_dut (
        .CLK         (CLK),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire),
        .flags       (flags),
        .illegal     (illegal)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        errors++;
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic core_pkg::reg_addr_t pick_reg();
        return core_pkg::reg_addr_t'(1 + next_rand() % 31);  // Never r0
    endfunction

    function automatic core_pkg::word_t encode(input logic [5:0] opc,
                                               input core_pkg::reg_addr_t r2,
                                               input logic [4:0] r1,
                                               input logic [15:0] imm);
        return {imm, opc, r2, r1};
    endfunction

    //////////////////////////////
    // Reference model

    function automatic core_pkg::word_t add_sub(input core_pkg::word_t x,
                                                input core_pkg::word_t y, input logic sub,
                                                output core_pkg::alu_flags_t f);
        logic [32:0] wide;
        wide = sub ? {1'b0, x} - {1'b0, y} : {1'b0, x} + {1'b0, y};
        f.carry = wide[32];  // Borrow on subtract
        if (sub)
            f.over = (x[31] != y[31]) && (x[31] != wide[31]);
        else
            f.over = (x[31] == y[31]) && (x[31] != wide[31]);
        f.zero = (wide[31:0] == 32'h0);
        f.sign = wide[31];
        return wide[31:0];
    endfunction

    function automatic logic cond_holds(input core_pkg::alu_flags_t f, input logic [3:0] c);
        logic t;
        case (c[2:0])
            3'd0: t = f.over;
            3'd1: t = f.carry;
            3'd2: t = f.zero;
            3'd3: t = f.carry | f.zero;
            3'd4: t = f.sign;
            3'd5: t = 1'b1;
            3'd6: t = f.sign ^ f.over;
            default: t = (f.sign ^ f.over) | f.zero;
        endcase
        return t ^ c[3];
    endfunction

    // Returns 0 for an unknown opcode
    function automatic logic model_step(input core_pkg::word_t w, output core_pkg::retire_t r);
        logic [5:0]           opc;
        core_pkg::reg_addr_t  r2;
        core_pkg::word_t      a, b, s5, s16, u16, res;
        logic [4:0]           amt;
        core_pkg::alu_flags_t nf;
        int                   mask;     // 0 none, 1 carry kept, 2 all
        logic                 we;
        opc = w[15:10];
        r2 = w[9:5];
        a = m_reg[w[4:0]];
        b = m_reg[r2];
        s5 = {{27{w[4]}}, w[4:0]};
        s16 = {{16{w[31]}}, w[31:16]};
        u16 = {16'h0, w[31:16]};
        amt = opc[4] ? w[4:0] : a[4:0];
        nf = '0;
        mask = 0;
        we = 1'b1;
        case (opc)
            6'h00: res = a;
            6'h10: res = s5;
            6'h01: begin res = add_sub(b, a, 1'b0, nf); mask = 2; end
            6'h11: begin res = add_sub(b, s5, 1'b0, nf); mask = 2; end
            6'h02: begin res = add_sub(b, a, 1'b1, nf); mask = 2; end
            6'h03: begin res = add_sub(b, a, 1'b1, nf); mask = 2; we = 1'b0; end
            6'h13: begin res = add_sub(b, s5, 1'b1, nf); mask = 2; we = 1'b0; end
            6'h04, 6'h14: begin res = b << amt; mask = 1; end
            6'h05, 6'h15: begin res = b >> amt; mask = 1; end
            6'h07, 6'h17: begin res = $signed(b) >>> amt; mask = 1; end
            6'h0c: begin res = b | a; mask = 1; end
            6'h0d: begin res = b & a; mask = 1; end
            6'h0e: begin res = b ^ a; mask = 1; end
            6'h0f: begin res = ~a; mask = 1; end
            6'h12: res = {31'h0, cond_holds(m_flags, w[3:0])};
            6'h28: res = a + s16;
            6'h29: begin res = add_sub(a, s16, 1'b0, nf); mask = 2; end
            6'h2c: begin res = a | u16; mask = 1; end
            6'h2d: begin res = a & u16; mask = 1; end
            6'h2e: begin res = a ^ u16; mask = 1; end
            6'h2f: res = a + {w[31:16], 16'h0};
            default: return 1'b0;
        endcase
        if (mask == 2) begin
            m_flags = nf;
        end else if (mask == 1) begin
            m_flags.over = 1'b0;
            m_flags.sign = res[31];
            m_flags.zero = (res == 32'h0);
        end
        if (r2 == 5'd0)
            we = 1'b0;
        if (we)
            m_reg[r2] = res;
        r.valid = 1'b1;
        r.reg_we = we;
        r.dest = r2;
        r.data = res;
        return 1'b1;
    endfunction

    //////////////////////////////
    // Checker, falling edge

    always @(negedge CLK) begin
        cyc = cyc + 1;
        if (cyc >= max_cyc) begin
            stop_run("The run went past its cycle limit without finishing");
        end else if (mon_on) begin
            if (ret_due[cyc])
                assert (retire === exp_ret[cyc]) else stop_run($sformatf(
                    "FAILED at %0t: retire %h, expected %h", $time, retire, exp_ret[cyc]));
            else
                assert (retire.valid === 1'b0) else stop_run($sformatf(
                    "FAILED at %0t: unexpected retire %h", $time, retire));
            assert (illegal === ill_due[cyc]) else stop_run($sformatf(
                "FAILED at %0t: illegal is %b, expected %b", $time, illegal, ill_due[cyc]));
            if (ill_due[cyc])
                pending--;
            if (flag_due[cyc]) begin
                exp_flags = flag_upd[cyc];
                pending--;
            end
            assert (flags === exp_flags) else stop_run($sformatf(
                "FAILED at %0t: flags %b, expected %b", $time, flags, exp_flags));
        end
    end

    //////////////////////////////
    // Drive helpers

    task automatic issue(input core_pkg::word_t w);
        core_pkg::retire_t r;
        int                due;
        @(posedge CLK);
        instr_valid <= 1'b1;
        instr <= w;
        due = cyc + 1;                      // Checker cycle of the strobe
        pending++;
        if (model_step(w, r)) begin
            exp_ret[due + 2] = r;
            ret_due[due + 2] = 1'b1;
            flag_upd[due + 3] = m_flags;
            flag_due[due + 3] = 1'b1;
        end else begin
            ill_due[due + 1] = 1'b1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge CLK);
        instr_valid <= 1'b0;
        while (pending > 0 && waited < 12) begin
            @(negedge CLK);
            waited++;
        end
        assert (pending == 0) else stop_run("Timed out waiting for instructions to retire");
    endtask

    // Full 32-bit random value through MOVHI then MOVEA
    task automatic load_random(input core_pkg::reg_addr_t r);
        logic [31:0] v;
        v = next_rand();
        issue(encode(6'h2f, r, 5'd0, v[31:16]));
        issue(encode(6'h28, r, r, v[15:0]));
    endtask

    //////////////////////////////
    // Directed tests

    task automatic check_reset();
        int          n;
        logic [31:0] v;
        for (n = 0; n < 6; n++) begin
            @(negedge CLK);
            assert (retire.valid === 1'b0 && illegal === 1'b0 && flags === '0)
                else stop_run($sformatf("FAILED at %0t: outputs active after reset", $time));
        end
        for (n = 1; n < 32; n++) begin
            v = next_rand();
            issue(encode(6'h28, core_pkg::reg_addr_t'(n), 5'd0, v[31:16]));
        end
        drain();
    endtask

    task automatic reg_form_ops();
        int                  i, k;
        core_pkg::reg_addr_t a, b;
        for (i = 0; i < 11; i++) begin
            for (k = 0; k < 6; k++) begin
                a = pick_reg();
                b = pick_reg();
                load_random(a);
                load_random(b);
                issue(encode(6'h03, a, b, 16'h0));      // Random carry going in
                issue(encode(reg_ops[i], b, a, 16'h0));
            end
            drain();
        end
    endtask

    task automatic imm_form_ops();
        int                  i, k;
        core_pkg::reg_addr_t r1, r2;
        logic [31:0]         v;
        for (i = 0; i < 6; i++) begin
            for (k = 0; k < 8; k++) begin
                r1 = pick_reg();
                r2 = pick_reg();
                v = next_rand();
                load_random(r2);
                issue(encode(imm5_ops[i], r2, v[4:0], 16'h0));
                load_random(r1);
                issue(encode(6'h29, r2, r1, v[15:0]));  // ADDI sets carry
                issue(encode(imm16_ops[i], r2, r1, v[31:16]));
            end
            drain();
        end
    endtask

    task automatic dependent_chain();
        int                  gap, k;
        core_pkg::reg_addr_t prev, other, tmp;
        for (gap = 1; gap <= 3; gap++) begin
            load_random(5'd5);
            load_random(5'd6);
            load_random(5'd7);
            drain();
            prev = 5'd6;
            other = 5'd7;
            for (k = 0; k < 8; k++) begin
                if (k % 2 == 0) begin
                    issue(encode(chain_ops[next_rand() % 5], other, prev, 16'h0));
                    tmp = prev;
                    prev = other;
                    other = tmp;
                end else begin
                    issue(encode(chain_ops[next_rand() % 5], prev, 5'd5, 16'h0));
                end
                idle(gap - 1);
            end
            drain();
        end
    endtask

    task automatic cmp_setf_conditions();
        logic [4:0] c;
        for (c = 0; c < 16; c++) begin
            load_random(5'd8);
            if (c % 3 == 0)
                issue(encode(6'h28, 5'd9, 5'd8, 16'h0));  // Equal operands
            else
                load_random(5'd9);
            issue(encode(6'h03, 5'd9, 5'd8, 16'h0));
            issue(encode(6'h12, 5'd10, c, 16'h0));
            drain();
        end
    endtask

    task automatic r0_and_illegal();
        load_random(5'd3);
        issue(encode(6'h01, 5'd0, 5'd3, 16'h0));
        issue(encode(6'h00, 5'd11, 5'd0, 16'h0));   // r0 read right behind
        issue(encode(6'h28, 5'd0, 5'd3, 16'h1234));
        idle(1);
        issue(encode(6'h01, 5'd12, 5'd0, 16'h0));
        drain();
        issue(encode(6'h06, 5'd4, 5'd3, 16'h0));
        issue(encode(6'h1c, 5'd4, 5'd3, 16'h0));
        issue(encode(6'h00, 5'd13, 5'd3, 16'h0));
        issue(encode(6'h2a, 5'd4, 5'd3, 16'hffff));
        idle(2);
        issue(encode(6'h3f, 5'd4, 5'd3, 16'h0));
        drain();
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        lcg_state = 32'h6dc9;
        m_flags = '0;
        exp_flags = '0;
        cyc = 0;
        pending = 0;
        errors = 0;
        mon_on = 1'b0;
        for (int n = 0; n < 32; n++)
            m_reg[n] = '0;
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        mon_on = 1'b1;
        check_reset();
        reg_form_ops();
        imm_form_ops();
        dependent_chain();
        cmp_setf_conditions();
        r0_and_illegal();
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+src
src/core_pkg.sv
src/reg_file.sv
src/instr_decode.sv
src/alu_execute.sv
src/result_writeback.sv
src/int_core.sv
testbench/tb_int_core.sv

//--- Bender.yml
package:
  name: int_core

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/reg_file.sv
      - src/instr_decode.sv
      - src/alu_execute.sv
      - src/result_writeback.sv
      - src/int_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_int_core.sv
